// File: source/r24bb_bus_pkg.sv
package r24bb_bus_pkg;

    //////////////////////////////
    // Bus words
    //////////////////////////////

    typedef logic [31:0] bus_addr_t;  // Byte address
    typedef logic [31:0] bus_data_t;  // Read and write data
    typedef logic [11:0] bus_ofs_t;   // Byte offset inside one block

    // Host side of a transfer, shared by every block
    // Per-block select travels on its own line
    typedef struct packed {
        bus_addr_t paddr;
        logic      pwrite;   // High for a write
        bus_data_t pwdata;
        logic      penable;  // Low in setup, high in access
    } bus_req_t;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Upper address half every mapped access must carry
    localparam logic [15:0] BUS_BASE = 16'h43C0;

    // Block numbers, taken from paddr[15:12]
    localparam logic [3:0] BLK_ROUTER = 4'd2;  // DAC output router
    localparam logic [3:0] BLK_DDSA   = 4'd5;  // First DDS
    localparam logic [3:0] BLK_DDSB   = 4'd6;  // Second DDS

    localparam int BLK_COUNT = 16;  // One select line per block code

    //////////////////////////////
    // Register offsets
    //////////////////////////////

    // DDS block
    localparam bus_ofs_t OFS_FREQ = 12'h000;  // Phase step
    localparam bus_ofs_t OFS_CTRL = 12'h004;  // Enable and waveform

    // Router block
    localparam bus_ofs_t OFS_ROUTE = 12'h000;  // Source per DAC output

endpackage

// File: source/r24bb_sig_pkg.sv
package r24bb_sig_pkg;

    //////////////////////////////
    // Sample words
    //////////////////////////////

    typedef logic signed [7:0]  sample_t;  // DAC and ADC sample
    typedef logic signed [15:0] audio_t;   // One audio channel

    //////////////////////////////
    // DDS
    //////////////////////////////

    // Waveform select, code 3 falls back to saw
    typedef enum logic [1:0] {
        SAW      = 2'd0,
        SQUARE   = 2'd1,
        TRIANGLE = 2'd2
    } wave_e;

    typedef logic [31:0] dds_freq_t;  // Phase step per clock

    // Control word
    // Sits in the low bits, upper bus bits read as zero
    typedef struct packed {
        logic  enable;  // Bit 2
        wave_e wave;    // Bits 1:0
    } dds_ctrl_t;

    //////////////////////////////
    // Router
    //////////////////////////////

    // Sample source per DAC output, codes 6 and 7 give zero
    typedef enum logic [2:0] {
        MUTE  = 3'd0,
        ADC_A = 3'd1,
        ADC_B = 3'd2,
        DDS_A = 3'd3,
        DDS_B = 3'd4,
        AUDIO = 3'd5
    } src_e;

    // Route word, upper bus bits read as zero
    typedef struct packed {
        src_e src_b;  // Bits 5:3, DAC B
        src_e src_a;  // Bits 2:0, DAC A
    } route_cfg_t;

endpackage

// File: source/apb_cfg_reg.sv
`timescale 1ns/1ps

module apb_cfg_reg #(
    parameter type                     cfg_t  = logic [31:0],
    parameter r24bb_bus_pkg::bus_ofs_t OFFSET = '0
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     sel_i,      // Block select from the decoder
    input  r24bb_bus_pkg::bus_req_t  bus_req_i,
    output cfg_t                     cfg_o,      // Held payload
    output logic                     wr_o,       // Write access to the block
    output r24bb_bus_pkg::bus_data_t rdata_o
);

    localparam int CFG_W = $bits(cfg_t);  // Payload bits kept

    logic hit;  // Offset matches this word
    cfg_t cfg_q;

    assign hit = bus_req_i.paddr[11:0] == OFFSET;

    // Access cycle of a write anywhere in the block
    assign wr_o = sel_i && bus_req_i.penable && bus_req_i.pwrite;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_q <= '0;
        end else if (wr_o && hit) begin
            cfg_q <= cfg_t'(bus_req_i.pwdata[CFG_W-1:0]);  // Upper bits dropped
        end
    end

    assign cfg_o = cfg_q;

    // Read back zero-extended to a bus word
    always_comb begin
        rdata_o = '0;
        if (hit) begin
            rdata_o[CFG_W-1:0] = cfg_q;
        end
    end

endmodule

// File: source/apb_decode.sv
`timescale 1ns/1ps

module apb_decode (
    input  logic                      psel_i,
    input  r24bb_bus_pkg::bus_req_t   bus_req_i,
    input  r24bb_bus_pkg::bus_data_t  blk_rdata_i [r24bb_bus_pkg::BLK_COUNT],
    output logic [r24bb_bus_pkg::BLK_COUNT-1:0] blk_sel_o,
    output r24bb_bus_pkg::bus_data_t  prdata_o
);

    //////////////////////////////
    // Block map
    //////////////////////////////

    // One bit per block that actually exists
    localparam logic [r24bb_bus_pkg::BLK_COUNT-1:0] BLK_MAP =
        (r24bb_bus_pkg::BLK_COUNT'(1) << r24bb_bus_pkg::BLK_ROUTER) |
        (r24bb_bus_pkg::BLK_COUNT'(1) << r24bb_bus_pkg::BLK_DDSA)   |
        (r24bb_bus_pkg::BLK_COUNT'(1) << r24bb_bus_pkg::BLK_DDSB);

    logic       base_hit;  // Upper half matches the board window
    logic [3:0] blk;       // Block field of the address
    logic [r24bb_bus_pkg::BLK_COUNT-1:0] blk_onehot;

    assign base_hit = bus_req_i.paddr[31:16] == r24bb_bus_pkg::BUS_BASE;
    assign blk      = bus_req_i.paddr[15:12];

    //////////////////////////////
    // Select lines
    //////////////////////////////

    always_comb begin
        blk_onehot      = '0;
        blk_onehot[blk] = 1'b1;
    end

    // Held through setup and access, slaves qualify with penable
    assign blk_sel_o = (psel_i && base_hit) ? (blk_onehot & BLK_MAP) : '0;

    //////////////////////////////
    // Read data
    //////////////////////////////

    // Unmapped block or foreign base gives zero
    always_comb begin
        prdata_o = '0;
        if (blk_sel_o[blk]) begin
            prdata_o = blk_rdata_i[blk];  // Registered contents of the block
        end
    end

endmodule

// File: source/dds_gen.sv
`timescale 1ns/1ps

module dds_gen #(
    parameter int PHASE_W = 32
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     sel_i,
    input  r24bb_bus_pkg::bus_req_t  bus_req_i,
    output r24bb_bus_pkg::bus_data_t rdata_o,
    output r24bb_sig_pkg::sample_t   sample_o
);

    r24bb_sig_pkg::dds_freq_t freq;   // Phase step
    r24bb_sig_pkg::dds_ctrl_t ctrl;   // Enable and waveform
    logic                     freq_wr;
    r24bb_bus_pkg::bus_data_t freq_rdata;
    r24bb_bus_pkg::bus_data_t ctrl_rdata;

    logic                   blk_wr;   // Any write to this block
    logic [PHASE_W-1:0]     phase_q;
    logic [7:0]             p;        // Top phase byte
    logic [7:0]             fold;     // Triangle folded at half cycle
    logic [7:0]             dbl;
    r24bb_sig_pkg::sample_t shaped;
    r24bb_sig_pkg::sample_t sample_q;

    //////////////////////////////
    // Config words
    //////////////////////////////

    apb_cfg_reg #(
        .cfg_t  (r24bb_sig_pkg::dds_freq_t),
        .OFFSET (r24bb_bus_pkg::OFS_FREQ)
    ) i_freq_reg (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (sel_i),
        .bus_req_i (bus_req_i),
        .cfg_o     (freq),
        .wr_o      (freq_wr),
        .rdata_o   (freq_rdata)
    );

    apb_cfg_reg #(
        .cfg_t  (r24bb_sig_pkg::dds_ctrl_t),
        .OFFSET (r24bb_bus_pkg::OFS_CTRL)
    ) i_ctrl_reg (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (sel_i),
        .bus_req_i (bus_req_i),
        .cfg_o     (ctrl),
        .wr_o      (),
        .rdata_o   (ctrl_rdata)
    );

    assign blk_wr  = freq_wr;  // Pulses on a write to either offset
    assign rdata_o = freq_rdata | ctrl_rdata;  // Only the addressed slot is nonzero

    //////////////////////////////
    // Phase accumulator
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i || blk_wr || !ctrl.enable) begin
            phase_q <= '0;  // Restart on any write, parked while disabled
        end else begin
            phase_q <= phase_q + PHASE_W'(freq);
        end
    end

    //////////////////////////////
    // Waveform shaper
    //////////////////////////////

    assign p    = phase_q[PHASE_W-1 -: 8];
    assign fold = p[7] ? ~p : p;            // Falling half mirrored
    assign dbl  = {fold[6:0], 1'b0};        // Full 8-bit swing

    always_comb begin
        case (ctrl.wave)
            r24bb_sig_pkg::SQUARE:   shaped = p[7] ? 8'sh80 : 8'sh7F;
            r24bb_sig_pkg::TRIANGLE: shaped = {~dbl[7], dbl[6:0]};  // Offset binary to signed
            default:                 shaped = p;                     // Saw, also code 3
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sample_q <= '0;
        end else begin
            sample_q <= ctrl.enable ? shaped : '0;  // Silent when off
        end
    end

    assign sample_o = sample_q;

endmodule

// File: source/dac_router.sv
`timescale 1ns/1ps

module dac_router (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     sel_i,
    input  r24bb_bus_pkg::bus_req_t  bus_req_i,
    output r24bb_bus_pkg::bus_data_t rdata_o,
    input  r24bb_sig_pkg::sample_t   adc_a_i,
    input  r24bb_sig_pkg::sample_t   adc_b_i,
    input  r24bb_sig_pkg::sample_t   dds_a_i,
    input  r24bb_sig_pkg::sample_t   dds_b_i,
    input  r24bb_sig_pkg::audio_t    aud_l_i,
    input  r24bb_sig_pkg::audio_t    aud_r_i,
    output r24bb_sig_pkg::sample_t   dac_a_o,
    output r24bb_sig_pkg::sample_t   dac_b_o
);

    r24bb_sig_pkg::route_cfg_t route;    // Source of each output
    r24bb_sig_pkg::audio_t     aud_sum;  // Mono mix, wraps
    r24bb_sig_pkg::sample_t    aud_smp;

    //////////////////////////////
    // Route word
    //////////////////////////////

    apb_cfg_reg #(
        .cfg_t  (r24bb_sig_pkg::route_cfg_t),
        .OFFSET (r24bb_bus_pkg::OFS_ROUTE)
    ) i_route_reg (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (sel_i),
        .bus_req_i (bus_req_i),
        .cfg_o     (route),
        .wr_o      (),
        .rdata_o   (rdata_o)
    );

    assign aud_sum = aud_l_i + aud_r_i;
    assign aud_smp = aud_sum[15:8];  // Upper byte only

    // Source mux shared by both outputs
    function automatic r24bb_sig_pkg::sample_t pick(input r24bb_sig_pkg::src_e src);
        r24bb_sig_pkg::sample_t s;
        case (src)
            r24bb_sig_pkg::ADC_A: s = adc_a_i;
            r24bb_sig_pkg::ADC_B: s = adc_b_i;
            r24bb_sig_pkg::DDS_A: s = dds_a_i;
            r24bb_sig_pkg::DDS_B: s = dds_b_i;
            r24bb_sig_pkg::AUDIO: s = aud_smp;
            default:              s = '0;  // Mute and spare codes
        endcase
        return s;
    endfunction

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dac_a_o <= '0;
            dac_b_o <= '0;
        end else begin
            dac_a_o <= pick(route.src_a);
            dac_b_o <= pick(route.src_b);
        end
    end

endmodule

// File: source/r24bb_core.sv
`timescale 1ns/1ps

module r24bb_core #(
    parameter int PHASE_W = 32  // DDS accumulator width
) (
    input  logic                     clk,
    input  logic                     rst_i,

    // Register bus
    input  logic                     psel_i,
    input  r24bb_bus_pkg::bus_req_t  bus_req_i,
    output r24bb_bus_pkg::bus_data_t prdata_o,

    // Sample inputs
    input  r24bb_sig_pkg::sample_t   adc_a_i,
    input  r24bb_sig_pkg::sample_t   adc_b_i,
    input  r24bb_sig_pkg::audio_t    aud_l_i,
    input  r24bb_sig_pkg::audio_t    aud_r_i,

    // DAC streams
    output r24bb_sig_pkg::sample_t   dac_a_o,
    output r24bb_sig_pkg::sample_t   dac_b_o
);

    logic [r24bb_bus_pkg::BLK_COUNT-1:0] blk_sel;
    r24bb_bus_pkg::bus_data_t            blk_rdata [r24bb_bus_pkg::BLK_COUNT];
    r24bb_bus_pkg::bus_data_t            router_rdata;
    r24bb_bus_pkg::bus_data_t            ddsa_rdata;
    r24bb_bus_pkg::bus_data_t            ddsb_rdata;
    r24bb_sig_pkg::sample_t              ddsa_smp;
    r24bb_sig_pkg::sample_t              ddsb_smp;

    //////////////////////////////
    // Bus decode
    //////////////////////////////

    // Slots with no block read zero
    always_comb begin
        for (int i = 0; i < r24bb_bus_pkg::BLK_COUNT; i++) begin
            blk_rdata[i] = '0;
        end
        blk_rdata[r24bb_bus_pkg::BLK_ROUTER] = router_rdata;
        blk_rdata[r24bb_bus_pkg::BLK_DDSA]   = ddsa_rdata;
        blk_rdata[r24bb_bus_pkg::BLK_DDSB]   = ddsb_rdata;
    end

    apb_decode i_apb_decode (
        .psel_i      (psel_i),
        .bus_req_i   (bus_req_i),
        .blk_rdata_i (blk_rdata),
        .blk_sel_o   (blk_sel),
        .prdata_o    (prdata_o)
    );

    //////////////////////////////
    // DDS pair
    //////////////////////////////

    dds_gen #(
        .PHASE_W (PHASE_W)
    ) i_ddsa (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (blk_sel[r24bb_bus_pkg::BLK_DDSA]),
        .bus_req_i (bus_req_i),
        .rdata_o   (ddsa_rdata),
        .sample_o  (ddsa_smp)
    );

    dds_gen #(
        .PHASE_W (PHASE_W)
    ) i_ddsb (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (blk_sel[r24bb_bus_pkg::BLK_DDSB]),
        .bus_req_i (bus_req_i),
        .rdata_o   (ddsb_rdata),
        .sample_o  (ddsb_smp)
    );

    //////////////////////////////
    // Output router
    //////////////////////////////

    dac_router i_dac_router (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (blk_sel[r24bb_bus_pkg::BLK_ROUTER]),
        .bus_req_i (bus_req_i),
        .rdata_o   (router_rdata),
        .adc_a_i   (adc_a_i),
        .adc_b_i   (adc_b_i),
        .dds_a_i   (ddsa_smp),
        .dds_b_i   (ddsb_smp),
        .aud_l_i   (aud_l_i),
        .aud_r_i   (aud_r_i),
        .dac_a_o   (dac_a_o),
        .dac_b_o   (dac_b_o)
    );

endmodule

// File: tests/r24bb_core_tb_ref.svh
//////////////////////////////
// Stimulus generator
//////////////////////////////

// Next LCG state, 32-bit wrap
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

//////////////////////////////
// Waveforms and routing
//////////////////////////////

// Expected sample for waveform code and top phase byte
function automatic r24bb_sig_pkg::sample_t wave_ref(input logic [1:0] wave,
                                                    input logic [7:0] p);
    int                     pv;
    int                     fold;  // Mirrored in the upper half
    r24bb_sig_pkg::sample_t res;
    pv   = int'(p);
    fold = (pv >= 128) ? 255 - pv : pv;
    case (wave)
        r24bb_sig_pkg::SQUARE:   res = (pv >= 128) ? 8'sh80 : 8'sh7F;
        r24bb_sig_pkg::TRIANGLE: res = r24bb_sig_pkg::sample_t'(2 * fold - 128);
        default:                 res = r24bb_sig_pkg::sample_t'((pv >= 128) ? pv - 256 : pv);
    endcase
    return res;
endfunction

// Mono mix, upper byte of the wrapped 16-bit sum
function automatic r24bb_sig_pkg::sample_t audio_ref(input r24bb_sig_pkg::audio_t l,
                                                     input r24bb_sig_pkg::audio_t r);
    int sum;
    sum = (int'(l) + int'(r)) & 32'hFFFF;
    return r24bb_sig_pkg::sample_t'(sum >> 8);
endfunction

// Source code to sample, spare codes silent
function automatic r24bb_sig_pkg::sample_t route_ref(input logic [2:0] src,
    input r24bb_sig_pkg::sample_t adc_a, input r24bb_sig_pkg::sample_t adc_b,
    input r24bb_sig_pkg::sample_t dds_a, input r24bb_sig_pkg::sample_t dds_b,
    input r24bb_sig_pkg::sample_t aud);
    r24bb_sig_pkg::sample_t res;
    case (src)
        r24bb_sig_pkg::ADC_A: res = adc_a;
        r24bb_sig_pkg::ADC_B: res = adc_b;
        r24bb_sig_pkg::DDS_A: res = dds_a;
        r24bb_sig_pkg::DDS_B: res = dds_b;
        r24bb_sig_pkg::AUDIO: res = aud;
        default:              res = '0;
    endcase
    return res;
endfunction

// File: tests/r24bb_core_tb.sv
`timescale 1ns/1ps

module r24bb_core_tb;

    localparam int PERIOD    = 100;
    localparam int RST_CYC   = 3;
    localparam int BUS_OPS   = 49;  // Transfers in the sequence, two cycles each
    localparam int ROUTE_RUN = 16;
    localparam int WAVE_RUN  = 64;
    localparam int SIDE_RUN  = 40;
    localparam int TEST_CYC  = RST_CYC + 2 * BUS_OPS + 5 * ROUTE_RUN + 3 * WAVE_RUN
                               + 3 * SIDE_RUN;
    localparam int MARGIN    = 100;

    // Mapped words: route, DDS A freq and ctrl, DDS B freq and ctrl
    localparam r24bb_bus_pkg::bus_addr_t WORD_ADDR [5] = '{32'h43C0_2000, 32'h43C0_5000,
        32'h43C0_5004, 32'h43C0_6000, 32'h43C0_6004};
    localparam r24bb_bus_pkg::bus_data_t WORD_MASK [5] = '{32'h3F, 32'hFFFF_FFFF, 32'h7,
        32'hFFFF_FFFF, 32'h7};
    // Empty blocks 0 and 7, spare offsets, foreign base
    localparam r24bb_bus_pkg::bus_addr_t BAD_ADDR [5] = '{32'h43C0_0000, 32'h43C0_7000,
        32'h43C0_5008, 32'h43C0_2004, 32'h43C1_5000};
    localparam r24bb_bus_pkg::bus_data_t ROUTES [5] = '{32'o21, 32'o12, 32'o55, 32'o60, 32'o07};
    localparam logic [3:0] DDS_BLK [2] = '{4'd5, 4'd6};

    logic clk = 1'b0;
    logic rst_i;
    logic psel_i;
    r24bb_bus_pkg::bus_req_t  bus_req_i;
    r24bb_bus_pkg::bus_data_t prdata_o;
    r24bb_sig_pkg::sample_t   adc_a_i;
    r24bb_sig_pkg::sample_t   adc_b_i;
    r24bb_sig_pkg::audio_t    aud_l_i;
    r24bb_sig_pkg::audio_t    aud_r_i;
    r24bb_sig_pkg::sample_t   dac_a_o;
    r24bb_sig_pkg::sample_t   dac_b_o;

    logic [31:0] rng = 32'h3211_4996;
    int sample_errs;
    int word_errs;
    int n_checks;
    r24bb_bus_pkg::bus_data_t exp_word [5];

    // Model pipeline
    r24bb_sig_pkg::dds_freq_t m_freq [2];
    logic [2:0]               m_ctrl [2];  // Enable on bit 2
    logic [5:0]               m_route;     // src_b over src_a
    logic [31:0]              m_phase [2];
    r24bb_sig_pkg::sample_t   m_smp [2];
    r24bb_sig_pkg::sample_t   m_dac [2];

    `include "r24bb_core_tb_ref.svh"

    r24bb_core i_r24bb_core (.*);

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng = lcg_next(rng);
        return rng;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_sample(input r24bb_sig_pkg::sample_t got,
                                input r24bb_sig_pkg::sample_t exp, input string what);
        if (got !== exp) begin
            sample_errs++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input r24bb_bus_pkg::bus_data_t got,
                              input r24bb_bus_pkg::bus_data_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // Bus and stimulus tasks
    //////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Setup now, access next cycle, write lands at the edge after
    task automatic bus_write(input r24bb_bus_pkg::bus_addr_t addr,
                             input r24bb_bus_pkg::bus_data_t data);
        psel_i    = 1'b1;
        bus_req_i = '{paddr: addr, pwrite: 1'b1, pwdata: data, penable: 1'b0};
        next_cycle();
        bus_req_i.penable = 1'b1;
        next_cycle();
        psel_i    = 1'b0;
        bus_req_i = '0;
    endtask

    task automatic read_expect(input r24bb_bus_pkg::bus_addr_t addr,
                               input r24bb_bus_pkg::bus_data_t exp, input string what);
        r24bb_bus_pkg::bus_data_t rd;
        psel_i    = 1'b1;
        bus_req_i = '{paddr: addr, pwrite: 1'b0, pwdata: '0, penable: 1'b0};
        next_cycle();
        bus_req_i.penable = 1'b1;
        @(negedge clk);
        rd = prdata_o;  // Mid access cycle
        check_word(rd, exp, what);
        next_cycle();
        psel_i    = 1'b0;
        bus_req_i = '0;
    endtask

    // Fresh ADC and audio values every cycle
    task automatic drive_random(input int n);
        repeat (n) begin
            adc_a_i = r24bb_sig_pkg::sample_t'(rand32() >> 24);
            adc_b_i = r24bb_sig_pkg::sample_t'(rand32() >> 24);
            aud_l_i = r24bb_sig_pkg::audio_t'(rand32() >> 16);
            aud_r_i = r24bb_sig_pkg::audio_t'(rand32() >> 16);
            next_cycle();
        end
    endtask

    //////////////////////////////
    // Model and compare
    //////////////////////////////

    // Old state feeds each stage, so later stages update first
    always @(posedge clk) begin
        logic       wr_en;
        logic [3:0] blk;
        logic [11:0] ofs;
        wr_en = psel_i && bus_req_i.penable && bus_req_i.pwrite
                && bus_req_i.paddr[31:16] == 16'h43C0;
        blk   = bus_req_i.paddr[15:12];
        ofs   = bus_req_i.paddr[11:0];
        if (rst_i) begin
            m_route = '0;
            m_freq  = '{default: '0};
            m_ctrl  = '{default: '0};
            m_phase = '{default: '0};
            m_smp   = '{default: '0};
            m_dac   = '{default: '0};
        end else begin
            m_dac[0] = route_ref(m_route[2:0], adc_a_i, adc_b_i, m_smp[0], m_smp[1],
                                 audio_ref(aud_l_i, aud_r_i));
            m_dac[1] = route_ref(m_route[5:3], adc_a_i, adc_b_i, m_smp[0], m_smp[1],
                                 audio_ref(aud_l_i, aud_r_i));
            for (int g = 0; g < 2; g++) begin
                m_smp[g] = m_ctrl[g][2] ? wave_ref(m_ctrl[g][1:0], m_phase[g][31:24]) : '0;
                if ((wr_en && blk == DDS_BLK[g]) || !m_ctrl[g][2]) begin
                    m_phase[g] = '0;  // Restart or parked
                end else begin
                    m_phase[g] = m_phase[g] + m_freq[g];
                end
                if (wr_en && blk == DDS_BLK[g] && ofs == 12'h000) begin
                    m_freq[g] = bus_req_i.pwdata;
                end
                if (wr_en && blk == DDS_BLK[g] && ofs == 12'h004) begin
                    m_ctrl[g] = bus_req_i.pwdata[2:0];
                end
            end
            if (wr_en && blk == 4'd2 && ofs == 12'h000) begin
                m_route = bus_req_i.pwdata[5:0];
            end
        end
    end

    always @(negedge clk) begin
        check_sample(dac_a_o, m_dac[0], "DAC A");
        check_sample(dac_b_o, m_dac[1], "DAC B");
        n_checks++;
    end

    // Watchdog
    initial begin
        #((TEST_CYC + MARGIN) * PERIOD);
        $display("Timeout: sequence not finished after %0d cycles", TEST_CYC + MARGIN);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        r24bb_bus_pkg::bus_data_t wdata;
        rst_i     = 1'b1;
        psel_i    = 1'b0;
        bus_req_i = '0;
        adc_a_i   = '0;
        adc_b_i   = '0;
        aud_l_i   = '0;
        aud_r_i   = '0;
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst_i = 1'b0;

        for (int i = 0; i < 5; i++) read_expect(WORD_ADDR[i], '0, "Reset value");

        // Read-back masked to payload width
        for (int i = 0; i < 5; i++) begin
            wdata       = rand32();
            exp_word[i] = wdata & WORD_MASK[i];
            bus_write(WORD_ADDR[i], wdata);
        end
        for (int i = 0; i < 5; i++) read_expect(WORD_ADDR[i], exp_word[i], "Read-back");
        for (int i = 0; i < 5; i++) read_expect(BAD_ADDR[i], '0, "Unmapped read");
        for (int i = 0; i < 5; i++) bus_write(BAD_ADDR[i], rand32());
        for (int i = 0; i < 5; i++) read_expect(WORD_ADDR[i], exp_word[i], "After stray write");

        // Straight, crossed, audio, mute and spare codes
        for (int r = 0; r < 5; r++) begin
            bus_write(WORD_ADDR[0], ROUTES[r]);
            drive_random(ROUTE_RUN);
        end

        // One waveform at a time on DDS A
        bus_write(WORD_ADDR[4], 32'h0);
        bus_write(WORD_ADDR[0], 32'o43);
        for (int w = 0; w < 3; w++) begin
            bus_write(WORD_ADDR[1], {8'(rand32() >> 24) | 8'd1, 24'h0});
            bus_write(WORD_ADDR[2], 32'(4 + w));
            run_cycles(WAVE_RUN);
        end

        // Both generators free running
        bus_write(WORD_ADDR[1], rand32());
        bus_write(WORD_ADDR[3], rand32());
        bus_write(WORD_ADDR[2], 32'h4 | (rand32() >> 30));
        bus_write(WORD_ADDR[4], 32'h4 | (rand32() >> 30));
        run_cycles(SIDE_RUN);
        bus_write(WORD_ADDR[1], rand32());  // Restart A only
        run_cycles(SIDE_RUN);
        bus_write(WORD_ADDR[4], 32'h0);
        run_cycles(SIDE_RUN);
        check_sample(dac_b_o, '0, "DAC B with DDS B off");

        $display("Compared %0d cycles: %0d sample errors, %0d word errors",
                 n_checks, sample_errs, word_errs);
        if (sample_errs + word_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: r24bb_core.f
+incdir+tests
source/r24bb_bus_pkg.sv
source/r24bb_sig_pkg.sv
source/apb_cfg_reg.sv
source/apb_decode.sv
source/dds_gen.sv
source/dac_router.sv
source/r24bb_core.sv
tests/r24bb_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the r24bb_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f r24bb_core.f \
    --top-module r24bb_core_tb \
    -o r24bb_core_sim

./obj_dir/r24bb_core_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
